// File: common/sa_cfg.svh
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

// Feature dimension, also the size of Wq and Wk
`define SA_DIM 8

// One lane per token
`define SA_MAX_TOKENS 8

// Input element width
`define SA_DATA_W 8

// Eight 16-bit products need three extra bits
`define SA_ACC_W 19

// Q.K dot product of eight 38-bit products
`define SA_SCORE_W 41

`endif

// File: common/sa_pkg.sv
`default_nettype none

package sa_pkg;

	`include "sa_cfg.svh"

	typedef logic signed [`SA_DATA_W-1:0] data_t;
	typedef logic signed [`SA_ACC_W-1:0] acc_t;
	typedef logic signed [`SA_SCORE_W-1:0] score_t;

	typedef logic [$clog2(`SA_DIM)-1:0] idx_t;
	typedef logic [$clog2(`SA_MAX_TOKENS+1)-1:0] tcount_t;

	// One Q or K row, element n at [n]
	typedef acc_t [`SA_DIM-1:0] lane_vec_t;

	typedef enum logic [1:0] {
		OP_NOP,
		OP_LOAD_X,
		OP_ACC_W
	} lane_op_e;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_DATA,
		PH_WEIGHT
	} load_phase_e;

	typedef enum logic {
		SC_IDLE,
		SC_EMIT
	} score_state_e;

	// Broadcast to every token lane, one per accepted beat
	typedef struct packed {
		lane_op_e op;
		idx_t row;
		idx_t col;
		data_t x;
		data_t wq;
		data_t wk;
	} lane_cmd_t;

endpackage

`default_nettype wire

// File: source/attn_loader.sv
`default_nettype none

module attn_loader import sa_pkg::*; (
	input logic k_clk,
	input logic rst_n,
	input logic in_valid,
	input tcount_t t,
	input data_t in_data,
	input data_t w_q,
	input data_t w_k,
	input logic score_busy,
	output lane_cmd_t lane_cmd,
	output logic scores_start,
	output tcount_t job_t
);

	load_phase_e phase;
	idx_t row;
	idx_t col;
	tcount_t t_last;
	logic accept;
	logic last_w;
	logic col_end;
	logic row_end;

	lane_op_e cmd_op;
	idx_t cmd_row;
	idx_t cmd_col;
	data_t cmd_x;
	data_t cmd_wq;
	data_t cmd_wk;

	assign t_last = job_t - 1'b1;

	// Command for the final Wq/Wk element is on the bus
	assign last_w = (cmd_op == OP_ACC_W) && (&cmd_row) && (&cmd_col);

	// Nothing is taken in until the score pass has let go
	assign accept = in_valid && !score_busy && !scores_start && !last_w;

	assign col_end = (col == idx_t'(`SA_DIM - 1));
	assign row_end = (phase == PH_WEIGHT) ? (row == idx_t'(`SA_DIM - 1))
		: (row == t_last[$bits(idx_t)-1:0]);

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			row <= '0;
			col <= '0;
			job_t <= '0;
			cmd_op <= OP_NOP;
			scores_start <= 1'b0;
		end else begin
			scores_start <= last_w;
			cmd_op <= OP_NOP;
			if (accept) begin
				cmd_op <= (phase == PH_WEIGHT) ? OP_ACC_W : OP_LOAD_X;
				if (phase == PH_IDLE) begin
					// First beat carries T along with X[0][0]
					job_t <= t;
					phase <= PH_DATA;
					col <= col + 1'b1;
				end else if (col_end) begin
					col <= '0;
					if (row_end) begin
						row <= '0;
						phase <= (phase == PH_DATA) ? PH_WEIGHT : PH_IDLE;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Beat payload, only meaningful while cmd_op is not OP_NOP
	always_ff @(posedge k_clk) begin
		if (accept) begin
			cmd_row <= row;
			cmd_col <= col;
			cmd_x <= in_data;
			cmd_wq <= w_q;
			cmd_wk <= w_k;
		end
	end

	assign lane_cmd = '{
		op: cmd_op,
		row: cmd_row,
		col: cmd_col,
		x: cmd_x,
		wq: cmd_wq,
		wk: cmd_wk
	};

endmodule

`default_nettype wire

// File: source/token_lane.sv
`default_nettype none

`include "sa_cfg.svh"

module token_lane import sa_pkg::*; #(
	parameter int LANE_ID = 0
) (
	input logic k_clk,
	input logic rst_n,
	input lane_cmd_t lane_cmd,
	output lane_vec_t q_row,
	output lane_vec_t k_row
);

	data_t x_row [`SA_DIM];
	data_t x_sel;
	logic signed [2*`SA_DATA_W-1:0] q_prod;
	logic signed [2*`SA_DATA_W-1:0] k_prod;
	logic own_row;
	logic job_start;

	assign own_row = (lane_cmd.row == idx_t'(LANE_ID));

	// X[0][0] opens a new job in every lane
	assign job_start = (lane_cmd.op == OP_LOAD_X) && (lane_cmd.row == '0)
		&& (lane_cmd.col == '0);

	// Rank-one step: X[lane][r] times row r of both weight matrices
	assign x_sel = x_row[lane_cmd.row];
	assign q_prod = x_sel * lane_cmd.wq;
	assign k_prod = x_sel * lane_cmd.wk;

	always_ff @(posedge k_clk) begin
		if (lane_cmd.op == OP_LOAD_X && own_row) begin
			x_row[lane_cmd.col] <= lane_cmd.x;
		end
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			q_row <= '0;
			k_row <= '0;
		end else if (job_start) begin
			q_row <= '0;
			k_row <= '0;
		end else if (lane_cmd.op == OP_ACC_W) begin
			q_row[lane_cmd.col] <= q_row[lane_cmd.col] + q_prod;
			k_row[lane_cmd.col] <= k_row[lane_cmd.col] + k_prod;
		end
	end

endmodule

`default_nettype wire

// File: score_unit/score_unit.sv
`default_nettype none

`include "sa_cfg.svh"

module score_unit import sa_pkg::*; (
	input logic k_clk,
	input logic rst_n,
	input logic scores_start,
	input tcount_t job_t,
	input lane_vec_t q_rows [`SA_MAX_TOKENS],
	input lane_vec_t k_rows [`SA_MAX_TOKENS],
	output logic score_busy,
	output logic out_valid,
	output score_t out_data
);

	score_state_e state;
	idx_t row_i;
	idx_t col_j;
	tcount_t t_lat;
	tcount_t t_cur;
	tcount_t t_last;
	idx_t idx_last;
	logic emit;
	logic col_end;
	logic last_pair;
	lane_vec_t q_sel;
	lane_vec_t k_sel;
	score_t dot;
	score_t score;

	// The start edge already produces S[0][0], so T is taken straight from the loader
	assign t_cur = (state == SC_IDLE) ? job_t : t_lat;
	assign t_last = t_cur - 1'b1;
	assign idx_last = t_last[$bits(idx_t)-1:0];

	assign emit = scores_start || (state == SC_EMIT);
	assign col_end = (col_j == idx_last);
	assign last_pair = col_end && (row_i == idx_last);
	assign score_busy = (state == SC_EMIT);

	assign q_sel = q_rows[row_i];
	assign k_sel = k_rows[col_j];

	always_comb begin
		acc_t qa;
		acc_t kb;
		dot = '0;
		for (int n = 0; n < `SA_DIM; n++) begin
			qa = q_sel[n];
			kb = k_sel[n];
			dot = dot + qa * kb;
		end
		// Clamp at zero, then truncating divide by three
		if (dot[$bits(score_t)-1]) begin
			score = '0;
		end else begin
			score = dot / 3;
		end
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SC_IDLE;
			row_i <= '0;
			col_j <= '0;
			t_lat <= '0;
			out_valid <= 1'b0;
			out_data <= '0;
		end else begin
			if (scores_start) begin
				t_lat <= job_t;
			end
			if (emit) begin
				out_valid <= 1'b1;
				out_data <= score;
				if (last_pair) begin
					state <= SC_IDLE;
					row_i <= '0;
					col_j <= '0;
				end else begin
					state <= SC_EMIT;
					if (col_end) begin
						col_j <= '0;
						row_i <= row_i + 1'b1;
					end else begin
						col_j <= col_j + 1'b1;
					end
				end
			end else begin
				out_valid <= 1'b0;
				out_data <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/attn_score_top.sv
`default_nettype none

`include "sa_cfg.svh"

module attn_score_top import sa_pkg::*; (
	input logic k_clk,
	input logic rst_n,
	input logic in_valid,
	input tcount_t t,
	input data_t in_data,
	input data_t w_q,
	input data_t w_k,
	output logic out_valid,
	output score_t out_data
);

	lane_cmd_t lane_cmd;
	logic scores_start;
	logic score_busy;
	tcount_t job_t;
	lane_vec_t q_rows [`SA_MAX_TOKENS];
	lane_vec_t k_rows [`SA_MAX_TOKENS];

	attn_loader loader0 (
		.k_clk(k_clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.t(t),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.score_busy(score_busy),
		.lane_cmd(lane_cmd),
		.scores_start(scores_start),
		.job_t(job_t)
	);

	// One lane per token row of X, Q and K
	for (genvar g = 0; g < `SA_MAX_TOKENS; g++) begin : g_lane
		token_lane #(
			.LANE_ID(g)
		) lane (
			.k_clk(k_clk),
			.rst_n(rst_n),
			.lane_cmd(lane_cmd),
			.q_row(q_rows[g]),
			.k_row(k_rows[g])
		);
	end

	score_unit score0 (
		.k_clk(k_clk),
		.rst_n(rst_n),
		.scores_start(scores_start),
		.job_t(job_t),
		.q_rows(q_rows),
		.k_rows(k_rows),
		.score_busy(score_busy),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// File: sim/sa_assertions.sv
`default_nettype none

module sa_assertions import sa_pkg::*; (
	input logic k_clk,
	input logic rst_n,
	input logic out_valid,
	input score_t out_data,
	input logic scores_start,
	input lane_op_e lane_op
);

	// First edge out of reset sees an idle output
	idle_after_reset: assert property (@(posedge k_clk) $rose(rst_n) |-> !out_valid)
		else $error("out_valid high right after reset");

	quiet_data: assert property (@(posedge k_clk) disable iff (!rst_n)
		!out_valid |-> (out_data == '0))
		else $error("out_data nonzero while out_valid is low");

	// Clamped scores have the sign bit clear
	non_negative: assert property (@(posedge k_clk) disable iff (!rst_n)
		!out_data[$bits(score_t)-1])
		else $error("out_data is negative");

	start_emits: assert property (@(posedge k_clk) disable iff (!rst_n)
		scores_start |=> out_valid)
		else $error("scores_start fired but no score followed");

	// Beats arriving during emission never reach the lanes
	no_cmd_in_emit: assert property (@(posedge k_clk) disable iff (!rst_n)
		out_valid |-> (lane_op == OP_NOP))
		else $error("lane command issued while scores are emitted");

endmodule

bind attn_score_top sa_assertions asrt0 (
	.k_clk(k_clk),
	.rst_n(rst_n),
	.out_valid(out_valid),
	.out_data(out_data),
	.scores_start(scores_start),
	.lane_op(lane_cmd.op)
);

`default_nettype wire

// File: sim/tb_attn_score.sv
`default_nettype none

`include "sa_cfg.svh"

module tb_attn_score import sa_pkg::*; ();

	localparam int CLK_HALF = 4;
	localparam int RESET_CYCLES = 10;
	localparam int DIM = `SA_DIM;
	localparam int MAX_T = `SA_MAX_TOKENS;
	// Falling edges from the idle cycle after the last beat to the first score
	localparam int FIRST_SCORE_WAIT = 2;
	localparam int SCORE_WAIT_LIMIT = 20;

	logic k_clk;
	logic rst_n;
	logic in_valid;
	tcount_t t;
	data_t in_data;
	data_t w_q;
	data_t w_k;
	logic out_valid;
	score_t out_data;

	// Current job and its expected scores, row-major
	data_t x_m [MAX_T][DIM];
	data_t wq_m [DIM][DIM];
	data_t wk_m [DIM][DIM];
	score_t exp_s [MAX_T*MAX_T];
	int neg_dots;
	int err_count;
	int tests_run;
	int tests_failed;

	attn_score_top dut0 (
		.k_clk(k_clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.t(t),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	always #CLK_HALF k_clk = ~k_clk;

	task automatic note_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		err_count++;
	endtask

	task automatic compare_score(input string name, input score_t got, input score_t expected);
		if (got !== expected) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			err_count++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int expected);
		if (got != expected) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			err_count++;
		end
	endtask

	function automatic int job_cycles(input int tc, input int gap_max);
		return (tc * DIM + DIM * DIM) * (gap_max + 1) + tc * tc + 20;
	endfunction

	task automatic fill_random();
		for (int r = 0; r < MAX_T; r++) begin
			for (int c = 0; c < DIM; c++) begin
				x_m[r][c] = data_t'($urandom);
			end
		end
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				wq_m[r][c] = data_t'($urandom);
				wk_m[r][c] = data_t'($urandom);
			end
		end
	endtask

	// Q = X*Wq, K = X*Wk, S = clamp(Q*K^T) / 3
	task automatic compute_expected(input int tc);
		int q_m [MAX_T][DIM];
		int k_m [MAX_T][DIM];
		longint dot;
		neg_dots = 0;
		for (int i = 0; i < tc; i++) begin
			for (int n = 0; n < DIM; n++) begin
				q_m[i][n] = 0;
				k_m[i][n] = 0;
				for (int r = 0; r < DIM; r++) begin
					q_m[i][n] += int'(x_m[i][r]) * int'(wq_m[r][n]);
					k_m[i][n] += int'(x_m[i][r]) * int'(wk_m[r][n]);
				end
			end
		end
		for (int i = 0; i < tc; i++) begin
			for (int j = 0; j < tc; j++) begin
				dot = 0;
				for (int n = 0; n < DIM; n++) begin
					dot += longint'(q_m[i][n]) * longint'(k_m[j][n]);
				end
				if (dot < 0) begin
					neg_dots++;
					exp_s[i * tc + j] = '0;
				end else begin
					exp_s[i * tc + j] = score_t'(dot / 3);
				end
			end
		end
	endtask

	task automatic idle_inputs();
		in_valid = 1'b0;
		t = tcount_t'($urandom);
		in_data = data_t'($urandom);
		w_q = data_t'($urandom);
		w_k = data_t'($urandom);
	endtask

	task automatic drive_beat(input tcount_t tv, input data_t d, input data_t q,
		input data_t k, input int gaps);
		repeat (gaps) begin
			@(negedge k_clk);
			idle_inputs();
		end
		@(negedge k_clk);
		in_valid = 1'b1;
		t = tv;
		in_data = d;
		w_q = q;
		w_k = k;
	endtask

	// Fields a beat does not use carry random values
	// T rides only on the first beat
	task automatic drive_job(input int tc, input int gap_max);
		int gaps;
		tcount_t tv;
		for (int r = 0; r < tc; r++) begin
			for (int c = 0; c < DIM; c++) begin
				gaps = (gap_max > 0 && (r + c) > 0) ? $urandom_range(gap_max, 0) : 0;
				tv = (r == 0 && c == 0) ? tcount_t'(tc) : tcount_t'($urandom);
				drive_beat(tv, x_m[r][c], data_t'($urandom), data_t'($urandom), gaps);
			end
		end
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				gaps = (gap_max > 0) ? $urandom_range(gap_max, 0) : 0;
				drive_beat(tcount_t'($urandom), data_t'($urandom), wq_m[r][c], wk_m[r][c],
					gaps);
			end
		end
		@(negedge k_clk);
		idle_inputs();
	endtask

	task automatic collect_scores(input int tc);
		int waited;
		int n;
		@(negedge k_clk);
		waited = 1;
		while (!out_valid && waited < SCORE_WAIT_LIMIT) begin
			@(negedge k_clk);
			waited++;
		end
		if (!out_valid) begin
			note_error($sformatf("no score appeared within %0d cycles of the last beat",
				SCORE_WAIT_LIMIT));
			return;
		end
		if (waited != FIRST_SCORE_WAIT) begin
			note_error($sformatf("first score came %0d cycles after the last beat, not %0d",
				waited, FIRST_SCORE_WAIT));
		end
		n = 0;
		while (out_valid && n <= tc * tc) begin
			if (n < tc * tc) begin
				compare_score($sformatf("out_data for S[%0d][%0d]", n / tc, n % tc),
					out_data, exp_s[n]);
			end
			n++;
			@(negedge k_clk);
		end
		compare_count("out_valid cycles", n, tc * tc);
	endtask

	// Random beats while scores stream out
	task automatic inject_noise(input int count);
		int waited;
		waited = 0;
		@(negedge k_clk);
		while (!out_valid && waited < SCORE_WAIT_LIMIT) begin
			@(negedge k_clk);
			waited++;
		end
		repeat (count) begin
			in_valid = 1'b1;
			t = tcount_t'($urandom_range(MAX_T, 1));
			in_data = data_t'($urandom);
			w_q = data_t'($urandom);
			w_k = data_t'($urandom);
			@(negedge k_clk);
		end
		idle_inputs();
	endtask

	task automatic run_job(input int tc, input int gap_max);
		compute_expected(tc);
		drive_job(tc, gap_max);
		collect_scores(tc);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic full_random_job();
		int errs;
		errs = err_count;
		fill_random();
		run_job(8, 0);
		finish_test("full random job, T=8", errs);
	endtask

	task automatic single_token_job();
		int errs;
		errs = err_count;
		fill_random();
		run_job(1, 0);
		finish_test("single token job, T=1", errs);
	endtask

	// Scores are 2*X*X^T with mixed signs and inexact thirds
	task automatic negative_scores_job();
		int errs;
		errs = err_count;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				x_m[r][c] = '0;
				wq_m[r][c] = (r == c) ? 8'sd2 : 8'sd0;
				wk_m[r][c] = (r == c) ? 8'sd1 : 8'sd0;
			end
		end
		x_m[0][0] = 8'sd3;
		x_m[0][1] = 8'sd1;
		x_m[1][0] = -8'sd2;
		x_m[1][1] = 8'sd1;
		x_m[2][0] = 8'sd1;
		x_m[2][1] = -8'sd3;
		x_m[2][2] = 8'sd2;
		x_m[3][1] = 8'sd2;
		x_m[3][2] = -8'sd1;
		compute_expected(4);
		if (neg_dots == 0) begin
			note_error("the chosen weights gave no negative dot products");
		end
		drive_job(4, 0);
		collect_scores(4);
		finish_test("negative scores clamp, T=4", errs);
	endtask

	task automatic gapped_input_job();
		int errs;
		errs = err_count;
		fill_random();
		run_job(5, 3);
		finish_test("gaps in in_valid, T=5", errs);
	endtask

	task automatic back_to_back_jobs();
		int errs;
		errs = err_count;
		fill_random();
		run_job(7, 0);
		fill_random();
		run_job(3, 0);
		finish_test("back-to-back jobs, T=7 then T=3", errs);
	endtask

	task automatic ignored_beats_job();
		int errs;
		errs = err_count;
		fill_random();
		compute_expected(6);
		drive_job(6, 0);
		fork
			collect_scores(6);
			inject_noise(6 * 6 - 3);
		join
		// A job opened by the stray beats would throw this one out of step
		fill_random();
		run_job(2, 0);
		finish_test("beats during emission ignored, T=6", errs);
	endtask

	initial begin
		int budget;
		void'($urandom(32'hd758_66e7));
		k_clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		t = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
		budget = RESET_CYCLES + 20 + job_cycles(8, 0) + job_cycles(1, 0) + job_cycles(4, 0)
			+ job_cycles(5, 3) + job_cycles(7, 0) + job_cycles(3, 0) + job_cycles(6, 0)
			+ job_cycles(2, 0);
		fork
			begin
				#(budget * 2 * CLK_HALF);
				$display("Watchdog expired after %0d cycles with tests still running", budget);
				$display("** FAIL **");
				$finish;
			end
			begin
				repeat (RESET_CYCLES) @(negedge k_clk);
				rst_n = 1'b1;
				full_random_job();
				single_token_job();
				negative_scores_job();
				gapped_input_job();
				back_to_back_jobs();
				ignored_beats_job();
			end
		join_any
		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			err_count);
		if (err_count == 0 && tests_failed == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/sa_pkg.sv
source/attn_loader.sv
source/token_lane.sv
score_unit/score_unit.sv
source/attn_score_top.sv
sim/sa_assertions.sv
sim/tb_attn_score.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP ?= tb_attn_score
RTL_TOP ?= attn_score_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing --assert

SOURCES := $(wildcard common/*.sv common/*.svh source/*.sv score_unit/*.sv sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG) || ! grep -qF '** PASS **' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
